/* src/lms_fe_defs.svh */
`ifndef LMS_FE_DEFS_SVH
`define LMS_FE_DEFS_SVH

// One word on the LMS6002D parallel data bus
`define LMS_WORD_W 12

// Zero bits appended below each received word
`define LMS_PAD_W 2

// Receive sample as handed to the DSP side
`define LMS_SAMPLE_W (`LMS_WORD_W + `LMS_PAD_W)

`endif

/* src/lms_fe_pkg.sv */
`include "lms_fe_defs.svh"

package lms_fe_pkg;

   // Raw word as it appears on an RX or TX data bus
   typedef logic [`LMS_WORD_W-1:0] lms_word_t;

   // Widened receive sample pair
   typedef struct packed
   {
      logic [`LMS_SAMPLE_W-1:0] i;
      logic [`LMS_SAMPLE_W-1:0] q;
   } iq_sample_t;

   // Both receive channels, aligned
   typedef struct packed
   {
      iq_sample_t ch1;
      iq_sample_t ch2;
   } dual_frame_t;

   // One transmit I/Q pair before interleaving
   typedef struct packed
   {
      lms_word_t i;
      lms_word_t q;
   } tx_pair_t;

endpackage

/* src/lms_rx_capture.sv */
`timescale 1ns/1ps
`include "lms_fe_defs.svh"

// One LMS receive channel. The ADC puts I and Q on the same 12-bit bus,
// IQSEL high for I and low for Q. A pair counts only when a Q word comes
// directly after an I word.
module lms_rx_capture
(
   input  logic                   lms_clk,
   input  logic                   rst_n_i,
   input  lms_fe_pkg::lms_word_t  rx_d_i,
   input  logic                   rx_iqsel_i,   // High marks an I word
   output lms_fe_pkg::iq_sample_t sample_o,     // Held until the next pair
   output logic                   pair_stb_o
);

   logic [`LMS_SAMPLE_W-1:0] rx_wide;   // Bus word with padding appended
   logic [`LMS_SAMPLE_W-1:0] i_hold;    // I word waiting for its Q
   logic                     i_seen;    // Previous word was an I word
   logic                     q_done;    // This Q word closes a pair

   // Widening is a plain shift up by the pad width
   assign rx_wide = {rx_d_i, {`LMS_PAD_W{1'b0}}};

   assign q_done = !rx_iqsel_i && i_seen;

   always_ff @(posedge lms_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         i_seen     <= 1'b0;
         pair_stb_o <= 1'b0;
      end
      else
      begin
         i_seen     <= rx_iqsel_i;
         pair_stb_o <= q_done;   // One cycle per completed pair
      end
   end

   // I is parked in i_hold, so sample_o only moves when a whole pair is in
   always_ff @(posedge lms_clk)
   begin
      if (rx_iqsel_i)
      begin
         i_hold <= rx_wide;
      end
      else if (q_done)
      begin
         sample_o.i <= i_hold;
         sample_o.q <= rx_wide;
      end
   end

endmodule

/* src/lms_rx_combine.sv */
`timescale 1ns/1ps

// Aligns the two receive channels into one dual-channel frame.
// Each channel parks its latest pair until the other channel has one too.
module lms_rx_combine
(
   input  logic                    lms_clk,
   input  logic                    rst_n_i,
   input  lms_fe_pkg::iq_sample_t  ch1_sample_i,
   input  lms_fe_pkg::iq_sample_t  ch2_sample_i,
   input  logic                    ch1_stb_i,
   input  logic                    ch2_stb_i,
   output lms_fe_pkg::dual_frame_t frame_o,
   output logic                    frame_stb_o,
   output logic                    skew_o        // Sticky until reset
);

   import lms_fe_pkg::*;

   iq_sample_t ch1_pend;      // Latest pair per channel
   iq_sample_t ch2_pend;
   logic [1:0] stb_in;        // Bit 0 is channel 1
   logic [1:0] pend_flag;
   logic [1:0] skew_hit;
   logic       issue;         // Both channels have a pair waiting

   assign stb_in = {ch2_stb_i, ch1_stb_i};
   assign issue  = &pend_flag;

   // A pair that lands on the issue edge is a fresh one, not a skew
   assign skew_hit = stb_in & pend_flag & {2{!issue}};

   always_ff @(posedge lms_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         pend_flag   <= 2'b00;
         frame_stb_o <= 1'b0;
         skew_o      <= 1'b0;
      end
      else
      begin
         // New strobe sets, issue clears
         pend_flag   <= stb_in | (pend_flag & {2{!issue}});
         frame_stb_o <= issue;
         if (|skew_hit)
         begin
            skew_o <= 1'b1;
         end
      end
   end

   // A second pair before the frame goes out replaces the first
   always_ff @(posedge lms_clk)
   begin
      if (ch1_stb_i)
      begin
         ch1_pend <= ch1_sample_i;
      end
      if (ch2_stb_i)
      begin
         ch2_pend <= ch2_sample_i;
      end
      if (issue)
      begin
         frame_o.ch1 <= ch1_pend;   // Old values, even if overwritten now
         frame_o.ch2 <= ch2_pend;
      end
   end

endmodule

/* src/lms_tx_interleave.sv */
`timescale 1ns/1ps

// Feeds both LMS DACs. Each bus carries I then Q on alternate cycles,
// with IQSEL low for I and high for Q.
module lms_tx_interleave
(
   input  logic                  lms_clk,
   input  logic                  rst_n_i,
   input  lms_fe_pkg::tx_pair_t  tx1_pair_i,
   input  lms_fe_pkg::tx_pair_t  tx2_pair_i,
   output lms_fe_pkg::lms_word_t tx1_d_o,
   output lms_fe_pkg::lms_word_t tx2_d_o,
   output logic                  tx1_iqsel_o,
   output logic                  tx2_iqsel_o
);

   import lms_fe_pkg::*;

   logic      iq_phase;     // High while Q is on the bus
   lms_word_t tx1_q_hold;   // Q half of the pair taken at the I edge
   lms_word_t tx2_q_hold;

   // Shared phase keeps the two DACs in lockstep
   always_ff @(posedge lms_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         iq_phase <= 1'b1;   // First cycle out of reset is I
         tx1_d_o  <= '0;
         tx2_d_o  <= '0;
      end
      else
      begin
         iq_phase <= !iq_phase;
         if (iq_phase)
         begin
            tx1_d_o <= tx1_pair_i.i;
            tx2_d_o <= tx2_pair_i.i;
         end
         else
         begin
            tx1_d_o <= tx1_q_hold;
            tx2_d_o <= tx2_q_hold;
         end
      end
   end

   // Q is taken together with I so the pair on the bus is coherent
   always_ff @(posedge lms_clk)
   begin
      if (iq_phase)
      begin
         tx1_q_hold <= tx1_pair_i.q;
         tx2_q_hold <= tx2_pair_i.q;
      end
   end

   assign tx1_iqsel_o = iq_phase;
   assign tx2_iqsel_o = iq_phase;

endmodule

/* src/lms_frontend.sv */
`timescale 1ns/1ps

// LMS6002D data-path bridge. Two receive channels are captured and
// aligned into dual frames; two transmit pairs are interleaved onto the
// DAC buses.
module lms_frontend
(
   input  logic                    lms_clk,
   input  logic                    rst_n_i,

   // Receive buses
   input  lms_fe_pkg::lms_word_t   rx1_d_i,
   input  logic                    rx1_iqsel_i,
   input  lms_fe_pkg::lms_word_t   rx2_d_i,
   input  logic                    rx2_iqsel_i,

   // Transmit pairs
   input  lms_fe_pkg::tx_pair_t    tx1_pair_i,
   input  lms_fe_pkg::tx_pair_t    tx2_pair_i,

   // Aligned receive frames
   output lms_fe_pkg::dual_frame_t rx_frame_o,
   output logic                    rx_frame_stb_o,
   output logic                    rx_skew_o,

   // DAC buses
   output lms_fe_pkg::lms_word_t   tx1_d_o,
   output logic                    tx1_iqsel_o,
   output lms_fe_pkg::lms_word_t   tx2_d_o,
   output logic                    tx2_iqsel_o
);

   import lms_fe_pkg::*;

   iq_sample_t rx1_sample;
   iq_sample_t rx2_sample;
   logic       rx1_pair_stb;
   logic       rx2_pair_stb;

   lms_rx_capture rx1_capture_i
   (
      .lms_clk    (lms_clk),
      .rst_n_i    (rst_n_i),
      .rx_d_i     (rx1_d_i),
      .rx_iqsel_i (rx1_iqsel_i),
      .sample_o   (rx1_sample),
      .pair_stb_o (rx1_pair_stb)
   );

   lms_rx_capture rx2_capture_i
   (
      .lms_clk    (lms_clk),
      .rst_n_i    (rst_n_i),
      .rx_d_i     (rx2_d_i),
      .rx_iqsel_i (rx2_iqsel_i),
      .sample_o   (rx2_sample),
      .pair_stb_o (rx2_pair_stb)
   );

   lms_rx_combine rx_combine_i
   (
      .lms_clk      (lms_clk),
      .rst_n_i      (rst_n_i),
      .ch1_sample_i (rx1_sample),
      .ch2_sample_i (rx2_sample),
      .ch1_stb_i    (rx1_pair_stb),
      .ch2_stb_i    (rx2_pair_stb),
      .frame_o      (rx_frame_o),
      .frame_stb_o  (rx_frame_stb_o),
      .skew_o       (rx_skew_o)
   );

   // Transmit side shares only clock and reset with receive
   lms_tx_interleave tx_interleave_i
   (
      .lms_clk     (lms_clk),
      .rst_n_i     (rst_n_i),
      .tx1_pair_i  (tx1_pair_i),
      .tx2_pair_i  (tx2_pair_i),
      .tx1_d_o     (tx1_d_o),
      .tx2_d_o     (tx2_d_o),
      .tx1_iqsel_o (tx1_iqsel_o),
      .tx2_iqsel_o (tx2_iqsel_o)
   );

endmodule

/* verification/lms_frontend_assert.sv */
`timescale 1ns/1ps

// Protocol properties of the LMS front end, bound to the top level
module lms_frontend_assert
(
   input logic lms_clk,
   input logic rst_n_i,
   input logic rx_frame_stb_i,
   input logic rx_skew_i,
   input logic tx1_iqsel_i,
   input logic tx2_iqsel_i
);

   // Both DAC selects flip each cycle once out of reset
   tx_select_toggles: assert property (@(posedge lms_clk) disable iff (!rst_n_i)
      $past(rst_n_i) |->
         (tx1_iqsel_i != $past(tx1_iqsel_i)) && (tx2_iqsel_i != $past(tx2_iqsel_i)))
   else $error("DAC selects did not alternate");

   frame_stb_single: assert property (@(posedge lms_clk) disable iff (!rst_n_i)
      rx_frame_stb_i |=> !rx_frame_stb_i)
   else $error("frame strobe high on two cycles in a row");

   skew_sticky: assert property (@(posedge lms_clk) disable iff (!rst_n_i)
      rx_skew_i |=> rx_skew_i)
   else $error("skew flag fell without reset");

   frame_stb_in_reset: assert property (@(posedge lms_clk)
      !rst_n_i |-> !rx_frame_stb_i)
   else $error("frame strobe high during reset");

endmodule

bind lms_frontend lms_frontend_assert frontend_assert_i
(
   .lms_clk        (lms_clk),
   .rst_n_i        (rst_n_i),
   .rx_frame_stb_i (rx_frame_stb_o),
   .rx_skew_i      (rx_skew_o),
   .tx1_iqsel_i    (tx1_iqsel_o),
   .tx2_iqsel_i    (tx2_iqsel_o)
);

/* verification/lms_frontend_tb.sv */
`timescale 1ns/1ps

module lms_frontend_tb;

   import lms_fe_pkg::*;

   localparam int FRAME_TIMEOUT = 16;   // Cycles allowed for a frame strobe
   localparam int SKEW_TIMEOUT  = 8;
   localparam int MAX_PAT       = 64;

   logic        lms_clk;
   logic        rst_n_i;
   lms_word_t   rx1_d_i;
   logic        rx1_iqsel_i;
   lms_word_t   rx2_d_i;
   logic        rx2_iqsel_i;
   tx_pair_t    tx1_pair_i;
   tx_pair_t    tx2_pair_i;
   dual_frame_t rx_frame_o;
   logic        rx_frame_stb_o;
   logic        rx_skew_o;
   lms_word_t   tx1_d_o;
   logic        tx1_iqsel_o;
   lms_word_t   tx2_d_o;
   logic        tx2_iqsel_o;

   logic [31:0] lcg_state;
   lms_word_t   pat [0:MAX_PAT-1][0:7];   // Columns as in the pattern file
   int          n_pat;
   logic        tx_sel_exp;               // DAC select due at this falling edge
   lms_word_t   tx1_q_exp;
   lms_word_t   tx2_q_exp;

   lms_frontend dut_i (.*);

   initial
   begin
      lms_clk = 1'b0;
      forever #5 lms_clk = ~lms_clk;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic fail_run(input string what);
      $display("%s", what);
      $display("CHECKS FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp)
      begin
         $display("ERR %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
         $display("CHECKS FAILED");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   task automatic load_patterns();
      int    fd;
      int    n;
      string line;
      fd = $fopen("verification/lms_frontend_patterns.txt", "r");
      if (fd == 0)
      begin
         fail_run("Cannot open the pattern file");
      end
      n_pat = 0;
      while (!$feof(fd) && n_pat < MAX_PAT)
      begin
         n = $fgets(line, fd);
         if (n > 0 && line.getc(0) != "/")
         begin
            n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                        pat[n_pat][0], pat[n_pat][1], pat[n_pat][2], pat[n_pat][3],
                        pat[n_pat][4], pat[n_pat][5], pat[n_pat][6], pat[n_pat][7]);
            if (n == 8)
            begin
               n_pat++;
            end
         end
      end
      $fclose(fd);
      if (n_pat < 6)
      begin
         fail_run("Too few lines in the pattern file");
      end
   endtask

   task automatic drive_rx(input logic sel1, input lms_word_t d1,
                           input logic sel2, input lms_word_t d2);
      rx1_iqsel_i = sel1;
      rx1_d_i     = d1;
      rx2_iqsel_i = sel2;
      rx2_d_i     = d2;
   endtask

   // Select low after a Q word never completes a pair
   task automatic drive_idle();
      logic [31:0] r;
      r = lcg_next();
      drive_rx(1'b0, r[11:0], 1'b0, r[27:16]);
   endtask

   task automatic check_quiet();
      check_eq(32'(rx_frame_stb_o), 32'd0, "frame strobe");
      check_eq(32'(rx_skew_o), 32'd0, "skew flag");
      check_eq(32'(tx1_d_o), 32'd0, "DAC 1 data");
      check_eq(32'(tx2_d_o), 32'd0, "DAC 2 data");
   endtask

   task automatic wait_frame(output int cycles);
      logic got;
      got    = 1'b0;
      cycles = 0;
      while (!got && cycles < FRAME_TIMEOUT)
      begin
         @(negedge lms_clk);
         drive_idle();
         cycles++;
         got = rx_frame_stb_o;
      end
      if (!got)
      begin
         fail_run("Timed out waiting for the receive frame strobe");
      end
   endtask

   // Expected samples are the bus words with two zero bits appended
   task automatic check_frame(input int k1, input int k2);
      check_eq(32'(rx_frame_o.ch1.i), 32'({pat[k1][0], 2'b00}), "frame ch1 I");
      check_eq(32'(rx_frame_o.ch1.q), 32'({pat[k1][1], 2'b00}), "frame ch1 Q");
      check_eq(32'(rx_frame_o.ch2.i), 32'({pat[k2][2], 2'b00}), "frame ch2 I");
      check_eq(32'(rx_frame_o.ch2.q), 32'({pat[k2][3], 2'b00}), "frame ch2 Q");
   endtask

   task automatic rx_pair_both(input int k);
      logic [31:0] r;
      int          delay;
      r = lcg_next();
      repeat (r[17:16])
      begin
         @(negedge lms_clk);
         drive_idle();
      end
      @(negedge lms_clk);
      drive_rx(1'b1, pat[k][0], 1'b1, pat[k][2]);
      @(negedge lms_clk);
      drive_rx(1'b0, pat[k][1], 1'b0, pat[k][3]);
      wait_frame(delay);
      // Third falling edge is two cycles after the Q edge
      check_eq(delay, 32'd3, "frame strobe delay");
      check_frame(k, k);
      check_eq(32'(rx_skew_o), 32'd0, "skew flag");
   endtask

   // Pairs changed here are held across the following Q cycle
   task automatic sync_tx_i_cycle();
      int n;
      n = 0;
      while (tx1_iqsel_o && n < 4)
      begin
         @(negedge lms_clk);
         n++;
      end
      if (tx1_iqsel_o)
      begin
         fail_run("Timed out waiting for a DAC I cycle");
      end
      tx_sel_exp = 1'b0;
      tx1_q_exp  = tx1_pair_i.q;
      tx2_q_exp  = tx2_pair_i.q;
   endtask

   // Inputs seen here were present at the last rising edge
   task automatic tx_step();
      @(negedge lms_clk);
      tx_sel_exp = !tx_sel_exp;
      check_eq(32'(tx1_iqsel_o), 32'(tx_sel_exp), "DAC 1 select");
      check_eq(32'(tx2_iqsel_o), 32'(tx_sel_exp), "DAC 2 select");
      if (!tx_sel_exp)
      begin
         check_eq(32'(tx1_d_o), 32'(tx1_pair_i.i), "DAC 1 I word");
         check_eq(32'(tx2_d_o), 32'(tx2_pair_i.i), "DAC 2 I word");
         tx1_q_exp = tx1_pair_i.q;
         tx2_q_exp = tx2_pair_i.q;
      end
      else
      begin
         check_eq(32'(tx1_d_o), 32'(tx1_q_exp), "DAC 1 Q word");
         check_eq(32'(tx2_d_o), 32'(tx2_q_exp), "DAC 2 Q word");
      end
   endtask

   initial
   begin
      int k;
      int n;
      int delay;
      lcg_state   = 32'h77e2_c821;
      tx_sel_exp  = 1'b0;
      rst_n_i     = 1'b1;
      rx1_d_i     = '0;
      rx1_iqsel_i = 1'b0;
      rx2_d_i     = '0;
      rx2_iqsel_i = 1'b0;
      tx1_pair_i  = '0;
      tx2_pair_i  = '0;
      load_patterns();
      #1;
      rst_n_i = 1'b0;   // Clean falling edge for the async reset
      repeat (10)
      begin
         @(negedge lms_clk);
         check_quiet();
      end
      rst_n_i = 1'b1;
      @(negedge lms_clk);
      check_quiet();
      check_eq(32'(tx1_iqsel_o), 32'd0, "first DAC select after reset");

      for (k = 0; k < n_pat - 4; k++)
      begin
         rx_pair_both(k);
      end

      // Q word with no I in front of it
      @(negedge lms_clk);
      drive_rx(1'b0, pat[n_pat-4][1], 1'b0, pat[n_pat-4][3]);
      repeat (8)
      begin
         @(negedge lms_clk);
         drive_idle();
         check_eq(32'(rx_frame_stb_o), 32'd0, "frame strobe after stray Q");
      end
      rx_pair_both(n_pat - 4);

      sync_tx_i_cycle();
      for (k = 0; k < n_pat; k++)
      begin
         tx1_pair_i.i = pat[k][4];
         tx1_pair_i.q = pat[k][5];
         tx2_pair_i.i = pat[k][6];
         tx2_pair_i.q = pat[k][7];
         repeat (8)
         begin
            tx_step();
         end
      end

      // Channel 1 runs two pairs ahead while channel 2 is idle
      k = n_pat - 3;
      for (int p = 0; p < 2; p++)
      begin
         @(negedge lms_clk);
         drive_rx(1'b1, pat[k+p][0], 1'b0, 12'h3c3);
         @(negedge lms_clk);
         drive_rx(1'b0, pat[k+p][1], 1'b0, 12'h3c3);
      end
      n = 0;
      while (!rx_skew_o && n < SKEW_TIMEOUT)
      begin
         @(negedge lms_clk);
         drive_idle();
         check_eq(32'(rx_frame_stb_o), 32'd0, "frame strobe with one channel");
         n++;
      end
      if (!rx_skew_o)
      begin
         fail_run("Timed out waiting for the skew flag");
      end
      repeat (4)
      begin
         @(negedge lms_clk);
         drive_idle();
         check_eq(32'(rx_skew_o), 32'd1, "sticky skew flag");
      end
      @(negedge lms_clk);
      drive_rx(1'b0, 12'h3c3, 1'b1, pat[k+2][2]);
      @(negedge lms_clk);
      drive_rx(1'b0, 12'h3c3, 1'b0, pat[k+2][3]);
      wait_frame(delay);
      check_eq(delay, 32'd3, "frame strobe delay after skew");
      check_frame(k + 1, k + 2);   // Second ch1 pair replaced the first
      check_eq(32'(rx_skew_o), 32'd1, "sticky skew flag");

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

/* verification/lms_frontend_patterns.txt */
// rx1_i rx1_q rx2_i rx2_q tx1_i tx1_q tx2_i tx2_q
// Hex bus words, one receive pair per channel and one transmit pair per channel per line
123 456 789 abc def 012 345 678
fff 000 800 7ff 001 ffe 555 aaa
a5a 5a5 3c3 c3c 0f0 f0f 111 eee
001 002 004 008 010 020 040 080
100 200 400 800 7fe bfd dfb efe
9d1 2e4 6b7 f08 3a9 c56 871 1cf
4e2 b3d 07a d69 e15 58c 2f0 a47
62c 917 c48 3b5 8e3 47d f92 06e
d05 a8e 53f 1c2 b76 0d9 9a4 e31
37b e60 f1d 846 25a c07 6ed 198
8b4 12f a69 5d0 cf8 731 04b 9e6
e9f 6c3 2b8 f74 41e 8a5 d3c 572
0c7 fb2 7e1 a1b 9f4 36d b20 e8a
5f6 d28 c9e 43a 167 e4c 7b9 20d
b12 49f 86c ddd 5e5 a13 c7f 3f1
2a0 c71 f3b 0e9 d84 61a 0a5 b5c
76e 05d 1a2 e7f 903 fc8 4d6 8ab
c34 8f9 bd4 629 3b0 1e7 e5e 74f

/* flist.f */
+incdir+src
src/lms_fe_pkg.sv
src/lms_rx_capture.sv
src/lms_rx_combine.sv
src/lms_tx_interleave.sv
src/lms_frontend.sv
verification/lms_frontend_assert.sv
verification/lms_frontend_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module lms_frontend_tb -f flist.f -o lms_frontend_sim > build.log 2>&1 \
   && ./obj_dir/lms_frontend_sim > sim.log 2>&1 \
   && ! grep -q "CHECKS FAILED" sim.log \
   && echo "Simulation passed, see sim.log" \
   || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
